/* npu_pkg.sv */
/*
 * Shared definitions for the NPU sequencer control plane.
 * Holds the microcode word layout, opcode encoding, widths and the GEMM
 * command type. Imported by every unit that decodes or carries commands.
 */
package npu_pkg;

    // ================================================
    // Widths and sizes
    // ================================================
    localparam int instr_w   = 128;
    localparam int uc_depth  = 1024;
    localparam int uc_addr_w = 10;
    localparam int field_w   = 16;
    localparam int flag_w    = 8;

    // Opcode byte, low end of every microcode word
    typedef enum logic [7:0] {
        op_nop     = 8'h00,
        op_gemm    = 8'h01,
        op_barrier = 8'h02,
        op_end     = 8'hff
    } opcode_e;

    // ================================================
    // Microcode word, 128 bits, MSB first
    // ================================================
    typedef struct packed {
        logic [field_w-1:0] imm;
        logic [field_w-1:0] k;
        logic [field_w-1:0] n;
        logic [field_w-1:0] m;
        logic [field_w-1:0] src1;
        logic [field_w-1:0] src0;
        logic [field_w-1:0] dst;
        logic [flag_w-1:0]  flags;
        opcode_e            opcode;
    } ucode_instr_t;

    // Command handed to the GEMM engine, 120 bits
    typedef struct packed {
        logic [field_w-1:0] src0;
        logic [field_w-1:0] src1;
        logic [field_w-1:0] dst;
        logic [field_w-1:0] m;
        logic [field_w-1:0] n;
        logic [field_w-1:0] k;
        logic [field_w-1:0] imm;
        logic [flag_w-1:0]  flags;
    } gemm_cmd_t;

endpackage

/* gemm_issue_if.sv */
/*
 * Decoder to GEMM shim link. Carries the command under a valid/ready
 * handshake plus the engine busy status used for barrier stalls.
 */
`timescale 1ns/1ps

interface gemm_issue_if
    import npu_pkg::*;
();

    logic      valid;
    logic      ready;
    gemm_cmd_t cmd;
    logic      busy;

    // Decoder side
    modport issuer (
        output valid,
        output cmd,
        input  ready,
        input  busy
    );

    // Shim side, ready is the inverse of busy
    modport engine (
        input  valid,
        input  cmd,
        output ready,
        output busy
    );

endinterface

/* ucode_store.sv */
/*
 * Microcode memory. One write port for program loading and one
 * registered read port for the fetch unit (data on the edge after rd_en).
 */
`timescale 1ns/1ps

module ucode_store
    import npu_pkg::*;
(
    input  logic                 clk,
    input  logic                 wr_en,
    input  logic [uc_addr_w-1:0] wr_addr,
    input  logic [instr_w-1:0]   wr_data,
    input  logic                 rd_en,
    input  logic [uc_addr_w-1:0] rd_addr,
    output logic [instr_w-1:0]   rd_data
);

    logic [instr_w-1:0] mem [uc_depth];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, same-address collision returns the old word
    // rd_data holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* ucode_fetch.sv */
/*
 * Microcode fetch. Walks the program from address 0, keeps one word in
 * flight and one held for the decoder, and absorbs op_end locally.
 * Raises done for one cycle when the program ends or runs out of words.
 */
`timescale 1ns/1ps

module ucode_fetch
    import npu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [uc_addr_w:0]   ucode_len,
    output logic                 rd_en,
    output logic [uc_addr_w-1:0] rd_addr,
    input  logic [instr_w-1:0]   rd_data,
    output logic                 instr_valid,
    input  logic                 instr_ready,
    output ucode_instr_t         instr_data,
    output logic                 done,
    output logic                 busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } fetch_state_e;

    fetch_state_e       state_q;
    logic [uc_addr_w:0] pc_q;
    logic               inflight_q;
    logic               hold_valid_q;
    ucode_instr_t       hold_q;
    logic               done_q;

    ucode_instr_t rd_word;
    logic         more;
    logic         in_is_end;
    logic         load_hold;
    logic         absorb_end;
    logic         finish;

    assign rd_word = rd_data;
    assign more    = pc_q < ucode_len;

    // ================================================
    // Word movement
    // ================================================
    assign in_is_end = inflight_q && (rd_word.opcode == op_end);
    assign load_hold = inflight_q && !in_is_end && (!hold_valid_q || instr_ready);

    // op_end waits until decode can take a new word, i.e. everything ahead
    // of it has left the decoder (a stalled barrier keeps it pending)
    assign absorb_end = in_is_end && !hold_valid_q && instr_ready;

    // Next read only when the in-flight slot frees up this cycle
    assign rd_en   = (state_q == st_run) && more && (!inflight_q || load_hold);
    assign rd_addr = pc_q[uc_addr_w-1:0];

    assign finish = absorb_end ||
                    ((state_q == st_drain) && !inflight_q && !hold_valid_q && instr_ready);

    // ================================================
    // Sequencing
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            pc_q       <= '0;
            inflight_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= finish;
            if (rd_en) begin
                pc_q <= pc_q + 1'b1;
            end
            if (finish) begin
                inflight_q <= 1'b0;
            end else if (rd_en) begin
                inflight_q <= 1'b1;
            end else if (load_hold) begin
                inflight_q <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= st_run;
                        pc_q    <= '0;
                    end
                end
                st_run: begin
                    if (finish) begin
                        state_q <= st_idle;
                    end else if (!more) begin
                        state_q <= st_drain;
                    end
                end
                st_drain: begin
                    if (finish) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Holding register presented to decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid_q <= 1'b0;
        end else if (load_hold) begin
            hold_valid_q <= 1'b1;
        end else if (instr_ready) begin
            hold_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_hold) begin
            hold_q <= rd_word;
        end
    end

    assign instr_valid = hold_valid_q;
    assign instr_data  = hold_q;
    assign done        = done_q;
    assign busy        = (state_q != st_idle);

    // Held word must not move under back-pressure
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr_data)
    ) else $error("fetch changed instr_data while stalled");

endmodule

/* ucode_decode.sv */
/*
 * In-order decoder with a single decode register. Builds GEMM commands,
 * stalls a barrier while the GEMM engine is busy and back-pressures fetch
 * whenever the held instruction cannot drain.
 */
`timescale 1ns/1ps

module ucode_decode
    import npu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         instr_valid,
    output logic         instr_ready,
    input  ucode_instr_t instr_data,
    gemm_issue_if.issuer gemm
);

    logic      held_q;
    opcode_e   op_q;
    gemm_cmd_t cmd_q;

    logic accept;
    logic drain;

    // Anything outside the issued set behaves as a NOP
    // (op_end never reaches here, fetch absorbs it)
    function automatic opcode_e decode_op(input opcode_e raw);
        case (raw)
            op_gemm:    return op_gemm;
            op_barrier: return op_barrier;
            default:    return op_nop;
        endcase
    endfunction

    // ================================================
    // Drain and accept
    // ================================================
    always_comb begin
        drain = 1'b0;
        if (held_q) begin
            case (op_q)
                op_gemm:    drain = gemm.valid && gemm.ready;
                op_barrier: drain = !gemm.busy;
                default:    drain = 1'b1;
            endcase
        end
    end

    assign instr_ready = !held_q || drain;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= 1'b0;
            op_q   <= op_nop;
        end else if (accept) begin
            held_q <= 1'b1;
            op_q   <= decode_op(instr_data.opcode);
        end else if (drain) begin
            held_q <= 1'b0;
        end
    end

    // Command built at accept, steady while held
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= '{
                src0:  instr_data.src0,
                src1:  instr_data.src1,
                dst:   instr_data.dst,
                m:     instr_data.m,
                n:     instr_data.n,
                k:     instr_data.k,
                imm:   instr_data.imm,
                flags: instr_data.flags
            };
        end
    end

    assign gemm.valid = held_q && (op_q == op_gemm);
    assign gemm.cmd   = cmd_q;

    // Offered GEMM stays put until the shim takes it
    a_gemm_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        gemm.valid && !gemm.ready |=> gemm.valid && op_q == op_gemm && $stable(gemm.cmd)
    ) else $error("GEMM command dropped or changed before transfer");

endmodule

/* gemm_shim.sv */
/*
 * GEMM engine stand-in. Captures each command, flags the capture for one
 * cycle and stays busy until the outside world returns a done pulse.
 */
`timescale 1ns/1ps

module gemm_shim
    import npu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    gemm_issue_if.engine gemm,
    output logic         cmd_captured,
    output gemm_cmd_t    cmd,
    input  logic         done_pulse
);

    logic      busy_q;
    logic      captured_q;
    gemm_cmd_t cmd_q;
    logic      xfer;

    assign gemm.ready = !busy_q;
    assign gemm.busy  = busy_q;
    assign xfer       = gemm.valid && gemm.ready;

    // Busy from transfer until done, a stray done is ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            captured_q <= 1'b0;
        end else begin
            captured_q <= xfer;
            if (xfer) begin
                busy_q <= 1'b1;
            end else if (done_pulse) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            cmd_q <= gemm.cmd;
        end
    end

    assign cmd_captured = captured_q;
    assign cmd          = cmd_q;

    // At least one done is needed between captures
    a_single_capture: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_captured |=> !cmd_captured
    ) else $error("back-to-back GEMM captures");

endmodule

/* npu_ctrl_top.sv */
/*
 * Sequencer control plane top. Connects microcode store, fetch, decode
 * and the GEMM shim, exposes captured commands on plain ports and keeps
 * a sticky program end flag until the next start.
 */
`timescale 1ns/1ps

module npu_ctrl_top
    import npu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_pulse,
    input  logic [uc_addr_w:0]   ucode_len,
    output logic                 program_end,
    input  logic                 uc_wr_en,
    input  logic [uc_addr_w-1:0] uc_wr_addr,
    input  logic [instr_w-1:0]   uc_wr_data,
    output logic                 gemm_cmd_captured,
    output logic [field_w-1:0]   gemm_src0,
    output logic [field_w-1:0]   gemm_src1,
    output logic [field_w-1:0]   gemm_dst,
    output logic [field_w-1:0]   gemm_m,
    output logic [field_w-1:0]   gemm_n,
    output logic [field_w-1:0]   gemm_k,
    output logic [field_w-1:0]   gemm_imm,
    output logic [flag_w-1:0]    gemm_flags,
    input  logic                 gemm_done_pulse,
    output logic                 gemm_busy,
    output logic                 all_idle
);

    logic                 uc_rd_en;
    logic [uc_addr_w-1:0] uc_rd_addr;
    logic [instr_w-1:0]   uc_rd_data;

    logic         instr_valid;
    logic         instr_ready;
    ucode_instr_t instr_data;
    logic         fetch_done;
    logic         fetch_busy;

    gemm_cmd_t shim_cmd;
    logic      program_end_q;

    gemm_issue_if gemm_issue ();

    // ================================================
    // Store and fetch
    // ================================================
    ucode_store ucode_store_i (
        .clk     (clk),
        .wr_en   (uc_wr_en),
        .wr_addr (uc_wr_addr),
        .wr_data (uc_wr_data),
        .rd_en   (uc_rd_en),
        .rd_addr (uc_rd_addr),
        .rd_data (uc_rd_data)
    );

    ucode_fetch ucode_fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start_pulse),
        .ucode_len   (ucode_len),
        .rd_en       (uc_rd_en),
        .rd_addr     (uc_rd_addr),
        .rd_data     (uc_rd_data),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .done        (fetch_done),
        .busy        (fetch_busy)
    );

    // ================================================
    // Decode and GEMM issue
    // ================================================
    ucode_decode ucode_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .gemm        (gemm_issue.issuer)
    );

    gemm_shim gemm_shim_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .gemm         (gemm_issue.engine),
        .cmd_captured (gemm_cmd_captured),
        .cmd          (shim_cmd),
        .done_pulse   (gemm_done_pulse)
    );

    // Sticky end flag, a start is only taken while fetch is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            program_end_q <= 1'b0;
        end else if (start_pulse && !fetch_busy) begin
            program_end_q <= 1'b0;
        end else if (fetch_done) begin
            program_end_q <= 1'b1;
        end
    end

    assign program_end = program_end_q;
    assign gemm_busy   = gemm_issue.busy;
    assign all_idle    = !fetch_busy && !gemm_issue.busy;

    // Captured command fields
    assign gemm_src0  = shim_cmd.src0;
    assign gemm_src1  = shim_cmd.src1;
    assign gemm_dst   = shim_cmd.dst;
    assign gemm_m     = shim_cmd.m;
    assign gemm_n     = shim_cmd.n;
    assign gemm_k     = shim_cmd.k;
    assign gemm_imm   = shim_cmd.imm;
    assign gemm_flags = shim_cmd.flags;

endmodule

/* tb_npu_ctrl.sv */
/*
 * Directed testbench for the NPU sequencer control plane.
 * Loads microcode, starts programs, answers GEMM captures with delayed
 * done pulses and checks captured fields, busy and program end timing.
 */
`timescale 1ns/1ps

module tb_npu_ctrl;
    import npu_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 start_pulse;
    logic [uc_addr_w:0]   ucode_len;
    logic                 program_end;
    logic                 uc_wr_en;
    logic [uc_addr_w-1:0] uc_wr_addr;
    logic [instr_w-1:0]   uc_wr_data;
    logic                 gemm_cmd_captured;
    logic [field_w-1:0]   gemm_src0;
    logic [field_w-1:0]   gemm_src1;
    logic [field_w-1:0]   gemm_dst;
    logic [field_w-1:0]   gemm_m;
    logic [field_w-1:0]   gemm_n;
    logic [field_w-1:0]   gemm_k;
    logic [field_w-1:0]   gemm_imm;
    logic [flag_w-1:0]    gemm_flags;
    logic                 gemm_done_pulse;
    logic                 gemm_busy;
    logic                 all_idle;

    ucode_instr_t prog[$];
    ucode_instr_t exp_q[$];
    int errors;
    int checks;
    int tests;
    int cap_count;
    int done_count;

    npu_ctrl_top npu_ctrl_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_pulse       (start_pulse),
        .ucode_len         (ucode_len),
        .program_end       (program_end),
        .uc_wr_en          (uc_wr_en),
        .uc_wr_addr        (uc_wr_addr),
        .uc_wr_data        (uc_wr_data),
        .gemm_cmd_captured (gemm_cmd_captured),
        .gemm_src0         (gemm_src0),
        .gemm_src1         (gemm_src1),
        .gemm_dst          (gemm_dst),
        .gemm_m            (gemm_m),
        .gemm_n            (gemm_n),
        .gemm_k            (gemm_k),
        .gemm_imm          (gemm_imm),
        .gemm_flags        (gemm_flags),
        .gemm_done_pulse   (gemm_done_pulse),
        .gemm_busy         (gemm_busy),
        .all_idle          (all_idle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ================================================
    // Reporting
    // ================================================
    task automatic check_eq(input string msg, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout at %0t ns: no %s seen within the allowed cycles", $time, what);
        errors++;
        finish_run();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("Test %-20s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // ================================================
    // Program building and loading
    // ================================================
    function automatic ucode_instr_t make_word(input opcode_e op);
        ucode_instr_t w;
        w.imm    = 16'($urandom());
        w.k      = 16'($urandom());
        w.n      = 16'($urandom());
        w.m      = 16'($urandom());
        w.src1   = 16'($urandom());
        w.src0   = 16'($urandom());
        w.dst    = 16'($urandom());
        w.flags  = 8'($urandom());
        w.opcode = op;
        return w;
    endfunction

    // GEMM words up to the first op_end or the length limit get issued
    function automatic void expect_until_end(input int len);
        exp_q.delete();
        for (int i = 0; i < len && i < prog.size(); i++) begin
            if (prog[i].opcode == op_end) break;
            if (prog[i].opcode == op_gemm) exp_q.push_back(prog[i]);
        end
    endfunction

    task automatic load_program();
        foreach (prog[i]) begin
            @(negedge clk);
            uc_wr_en   = 1'b1;
            uc_wr_addr = uc_addr_w'(i);
            uc_wr_data = prog[i];
        end
        @(negedge clk);
        uc_wr_en = 1'b0;
    endtask

    task automatic start_program(input int len);
        @(negedge clk);
        ucode_len   = len[uc_addr_w:0];
        start_pulse = 1'b1;
        @(negedge clk);
        start_pulse = 1'b0;
        check_eq("program_end cleared by start", program_end, 0);
    endtask

    // ================================================
    // GEMM responder and waits
    // ================================================
    task automatic respond(input int delay, input bit end_low);
        ucode_instr_t w;
        int n;
        n = 0;
        @(negedge clk);
        while (!gemm_cmd_captured) begin
            if (n == 200) fail_on_timeout("GEMM command capture");
            n++;
            @(negedge clk);
        end
        if (exp_q.size() == 0) begin
            $display("Unexpected GEMM capture at %0t ns with no command pending", $time);
            errors++;
        end else begin
            w = exp_q.pop_front();
            check_eq("gemm_src0", gemm_src0, w.src0);
            check_eq("gemm_src1", gemm_src1, w.src1);
            check_eq("gemm_dst", gemm_dst, w.dst);
            check_eq("gemm_m", gemm_m, w.m);
            check_eq("gemm_n", gemm_n, w.n);
            check_eq("gemm_k", gemm_k, w.k);
            check_eq("gemm_imm", gemm_imm, w.imm);
            check_eq("gemm_flags", gemm_flags, w.flags);
        end
        repeat (delay) begin
            @(negedge clk);
            check_eq("no capture while busy", gemm_cmd_captured, 0);
            check_eq("gemm_busy until done", gemm_busy, 1);
            check_eq("all_idle low while busy", all_idle, 0);
            if (end_low) check_eq("program_end before done", program_end, 0);
        end
        gemm_done_pulse = 1'b1;
        done_count++;
        @(negedge clk);
        gemm_done_pulse = 1'b0;
    endtask

    task automatic wait_program_end();
        int n;
        n = 0;
        while (!program_end) begin
            if (n == 500) fail_on_timeout("program_end");
            n++;
            @(negedge clk);
        end
    endtask

    // Every capture needs a done for the one before it
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && gemm_cmd_captured) begin
                check_eq("capture only after previous done", cap_count, done_count);
                check_eq("gemm_busy at capture", gemm_busy, 1);
                cap_count++;
            end
        end
    end

    // ================================================
    // Tests
    // ================================================
    task automatic after_reset();
        int e0;
        e0 = errors;
        check_eq("program_end after reset", program_end, 0);
        check_eq("captured after reset", gemm_cmd_captured, 0);
        check_eq("gemm_busy after reset", gemm_busy, 0);
        check_eq("all_idle after reset", all_idle, 1);
        report_test("after_reset", e0);
    endtask

    task automatic run_program(input string name, input int len, input int delay,
                               input bit end_low, input int caps);
        int e0;
        int base;
        e0   = errors;
        base = cap_count;
        load_program();
        expect_until_end(len);
        start_program(len);
        repeat (caps) respond(delay, end_low);
        wait_program_end();
        repeat (10) @(negedge clk);
        check_eq("capture count", cap_count - base, caps);
        check_eq("commands left over", exp_q.size(), 0);
        check_eq("all_idle after end", all_idle, 1);
        check_eq("gemm_busy after end", gemm_busy, 0);
        report_test(name, e0);
    endtask

    task automatic idle_done_and_rerun();
        int e0;
        int base;
        e0   = errors;
        base = cap_count;
        @(negedge clk);
        gemm_done_pulse = 1'b1;
        @(negedge clk);
        gemm_done_pulse = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_eq("gemm_busy after idle done", gemm_busy, 0);
        end
        check_eq("no capture from idle done", cap_count - base, 0);
        check_eq("program_end held until start", program_end, 1);
        expect_until_end(3);
        start_program(3);
        repeat (2) respond(3, 1'b0);
        wait_program_end();
        check_eq("rerun capture count", cap_count - base, 2);
        check_eq("rerun commands left over", exp_q.size(), 0);
        report_test("idle_done_and_rerun", e0);
    endtask

    initial begin
        void'($urandom(32'hc4ead7b7));
        rst_n           = 1'b0;
        start_pulse     = 1'b0;
        ucode_len       = '0;
        uc_wr_en        = 1'b0;
        uc_wr_addr      = '0;
        uc_wr_data      = '0;
        gemm_done_pulse = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        after_reset();

        prog = '{make_word(op_gemm), make_word(op_gemm), make_word(op_gemm), make_word(op_end)};
        run_program("three_gemms", 4, 2, 1'b0, 3);

        // Second GEMM has to wait for the first done pulse
        prog = '{make_word(op_gemm), make_word(op_gemm), make_word(op_end)};
        run_program("busy_blocks_issue", 3, 40, 1'b0, 2);

        prog = '{make_word(op_gemm), make_word(op_barrier), make_word(op_end)};
        run_program("barrier_waits", 3, 25, 1'b1, 1);

        // GEMM after op_end stays unissued
        prog = '{make_word(op_gemm), make_word(op_end), make_word(op_gemm)};
        run_program("after_end_ignored", 3, 3, 1'b0, 1);

        // Length limit ends the program before the last GEMM word
        prog = '{make_word(op_gemm), make_word(op_nop), make_word(op_gemm), make_word(op_gemm)};
        run_program("length_limit", 3, 3, 1'b0, 2);

        idle_done_and_rerun();
        finish_run();
    end

endmodule

/* all.f */
npu_pkg.sv
gemm_issue_if.sv
ucode_store.sv
ucode_fetch.sv
ucode_decode.sv
gemm_shim.sv
npu_ctrl_top.sv
tb_npu_ctrl.sv

/* Bender.yml */
package:
  name: npu_ctrl

sources:
  - npu_pkg.sv
  - gemm_issue_if.sv
  - ucode_store.sv
  - ucode_fetch.sv
  - ucode_decode.sv
  - gemm_shim.sv
  - npu_ctrl_top.sv
  - target: simulation
    files:
      - tb_npu_ctrl.sv
